/* Makefile */
# Verilator build of the text mode testbench

SOURCES = $(wildcard include/*.svh logic/*.sv test/*.sv)

.PHONY: all run clean

all: obj_dir/Vtext_mode_tb

obj_dir/Vtext_mode_tb: all.f $(SOURCES)
	verilator --binary --timing -Wno-fatal -f all.f --top-module text_mode_tb -o Vtext_mode_tb

run: obj_dir/Vtext_mode_tb
	./obj_dir/Vtext_mode_tb

clean:
	rm -rf obj_dir

/* all.f */
+incdir+include
logic/text_mode_pkg.sv
logic/cell_fifo.sv
logic/vga_timing.sv
logic/text_line_buffer.sv
logic/glyph_rom.sv
logic/text_pixel_decoder.sv
logic/video_text_mode.sv
test/text_mode_tb.sv

/* include/text_mode_settings.svh */
// text mode display settings

`ifndef TEXT_MODE_SETTINGS_SVH
`define TEXT_MODE_SETTINGS_SVH

// horizontal timing in pixels, 640x480 at 60 Hz
`define TM_H_ACTIVE     640
`define TM_H_TOTAL      800
`define TM_HSYNC_START  656
`define TM_HSYNC_END    752

// vertical timing in lines
`define TM_V_ACTIVE     480
`define TM_V_TOTAL      525
`define TM_VSYNC_START  490
`define TM_VSYNC_END    492

// text geometry, 80 columns of 8x16 glyphs
`define TM_COLS         80
`define TM_GLYPH_W      8
`define TM_GLYPH_H      16

`define TM_FIFO_DEPTH   128 // cells, power of two
`define TM_LOOKAHEAD    2   // counters lead the displayed pixel by this many cycles

`endif

/* logic/cell_fifo.sv */
// character cell fifo

`timescale 1ns/100ps

`include "text_mode_settings.svh"

module cell_fifo (
	input  logic                    pixel_clk_i,
	input  logic                    pixel_rstn_i,

	// host write side
	input  logic                    we_i,
	input  text_mode_pkg::text_cell_t cell_i,

	// line buffer read side
	input  logic                    pop_i,
	output text_mode_pkg::text_cell_t cell_o, // head cell, valid while not empty
	output logic                    empty_o,
	output logic                    full_o
);

	localparam int unsigned AW = $clog2(`TM_FIFO_DEPTH);

	text_mode_pkg::text_cell_t mem [`TM_FIFO_DEPTH];

	logic [AW-1:0] wr_ptr_q, rd_ptr_q;
	logic [AW:0]   count_q; // one extra bit to hold the full count
	logic          do_write, do_pop;

	assign empty_o = (count_q == '0);
	assign full_o  = (count_q == (AW+1)'(`TM_FIFO_DEPTH));

	assign do_write = we_i & ~full_o;  // writes on a full fifo are lost
	assign do_pop   = pop_i & ~empty_o; // pops on an empty fifo do nothing

	always_ff @(posedge pixel_clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_write)
				wr_ptr_q <= wr_ptr_q + 1'b1; // wraps naturally, depth is a power of two
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;

			case ({do_write, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q; // both or neither, level unchanged
			endcase
		end
	end

	// cell storage
	always_ff @(posedge pixel_clk_i) begin
		if (do_write)
			mem[wr_ptr_q] <= cell_i;
	end

	assign cell_o = mem[rd_ptr_q]; // show-ahead head

endmodule: cell_fifo

/* logic/glyph_rom.sv */
// 8x16 font rom

`timescale 1ns/100ps

module glyph_rom (
	input  logic       pixel_clk_i,
	input  logic       pixel_rstn_i,

	input  logic [7:0] code_i, // character code
	input  logic [3:0] row_i,  // scan line inside the glyph
	output logic [7:0] bits_o  // bit 7 is the leftmost pixel
);

	// font subset, undefined codes draw blank
	function automatic logic [7:0] glyph_row(input logic [7:0] code, input logic [3:0] row);
		logic [7:0] bits;
		bits = 8'h00;
		case (code)
			8'hDB: bits = 8'hFF;                             // solid block
			8'h5F: bits = (row == 4'd14) ? 8'hFF : 8'h00; // underscore
			8'h41: begin // 'A'
				case (row)
					4'd2:    bits = 8'h10;
					4'd3:    bits = 8'h38;
					4'd4:    bits = 8'h6C;
					4'd5,
					4'd6:    bits = 8'hC6;
					4'd7:    bits = 8'hFE; // crossbar
					4'd8,
					4'd9,
					4'd10,
					4'd11:   bits = 8'hC6;
					default: bits = 8'h00;
				endcase
			end
			8'h48: begin // 'H'
				case (row)
					4'd2,
					4'd3,
					4'd4,
					4'd5:    bits = 8'hC6;
					4'd6:    bits = 8'hFE;
					4'd7,
					4'd8,
					4'd9,
					4'd10,
					4'd11:   bits = 8'hC6;
					default: bits = 8'h00;
				endcase
			end
			default: bits = 8'h00; // 0x00, 0x20 and everything else
		endcase
		return bits;
	endfunction

	always_ff @(posedge pixel_clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i)
			bits_o <= '0;
		else
			bits_o <= glyph_row(code_i, row_i);
	end

endmodule: glyph_rom

/* logic/text_line_buffer.sv */
// text row line buffer

`timescale 1ns/100ps

`include "text_mode_settings.svh"

module text_line_buffer (
	input  logic                     pixel_clk_i,
	input  logic                     pixel_rstn_i,

	input  text_mode_pkg::scan_pos_t ahead_pos_i,
	input  logic                     flush_i,

	// cell fifo
	input  text_mode_pkg::text_cell_t fifo_cell_i,
	input  logic                     fifo_empty_i,
	output logic                     fifo_pop_o,

	// registered one cycle after the look-ahead pixel
	output text_mode_pkg::text_cell_t cell_o,
	output logic [2:0]               glyph_x_o,
	output logic [3:0]               glyph_y_o,
	output logic                     draw_o,

	output logic                     underrun_o // sticky until reset
);

	text_mode_pkg::text_cell_t store [`TM_COLS]; // one text row of cells
	text_mode_pkg::text_cell_t load_cell;
	text_mode_pkg::lb_state_e  state_q;

	logic [6:0] col;        // column of the look-ahead pixel
	logic [6:0] last_col_q; // column seen on the previous draw pixel
	logic       col_start;  // first pixel of a new column
	logic       load_col;   // fetch a fresh cell for this column

	assign col = 7'(ahead_pos_i.x / 10'(`TM_GLYPH_W));

	// comparing against the last column also catches column 0 right after reset,
	// where the counters start two pixels into the line
	assign col_start = ahead_pos_i.in_draw && (col != last_col_q);
	assign load_col  = (state_q == text_mode_pkg::LB_LOAD) && col_start;

	assign fifo_pop_o = load_col & ~fifo_empty_i;
	assign load_cell  = fifo_empty_i ? '0 : fifo_cell_i; // blank cell on underrun

	always_ff @(posedge pixel_clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i) begin
			state_q    <= text_mode_pkg::LB_LOAD;
			last_col_q <= '1; // out of range so column 0 counts as new
			underrun_o <= 1'b0;
			glyph_x_o  <= '0;
			glyph_y_o  <= '0;
			draw_o     <= 1'b0;
		end else begin
			// back to load at each row flush and through vertical blank
			if (flush_i || (ahead_pos_i.y >= 10'(`TM_V_ACTIVE)))
				state_q <= text_mode_pkg::LB_LOAD;
			else if ((state_q == text_mode_pkg::LB_LOAD) &&
					(ahead_pos_i.x == 10'(`TM_H_ACTIVE)))
				state_q <= text_mode_pkg::LB_REPLAY; // first scan line done

			if (ahead_pos_i.in_draw)
				last_col_q <= col;

			if (load_col && fifo_empty_i)
				underrun_o <= 1'b1;

			glyph_x_o <= 3'(ahead_pos_i.x % 10'(`TM_GLYPH_W)); // offset inside glyph
			glyph_y_o <= 4'(ahead_pos_i.y % 10'(`TM_GLYPH_H));
			draw_o    <= ahead_pos_i.in_draw;
		end
	end

	// cell store and output cell
	always_ff @(posedge pixel_clk_i) begin
		if (load_col)
			store[col] <= load_cell;
		if (ahead_pos_i.in_draw)
			cell_o <= load_col ? load_cell : store[col]; // bypass on the fetch pixel
	end

endmodule: text_line_buffer

/* logic/text_mode_pkg.sv */
// text mode shared types

package text_mode_pkg;

	// one character cell as written by the host
	typedef struct packed {
		logic [3:0] bg;   // background palette index
		logic [3:0] fg;   // foreground palette index
		logic [7:0] code; // character code
	} text_cell_t;

	// pixel position with its area and sync flags
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       in_draw; // inside 640x480
		logic       hsync_n; // active low
		logic       vsync_n; // active low
	} scan_pos_t;

	typedef enum logic {
		LB_LOAD,  // first scan line of a row, cells come from the fifo
		LB_REPLAY // remaining 15 lines reuse the stored cells
	} lb_state_e;

	// standard 16 colour cga palette, 24-bit rgb
	localparam logic [23:0] cga_palette [16] = '{
		24'h000000, 24'h0000AA, 24'h00AA00, 24'h00AAAA,
		24'hAA0000, 24'hAA00AA, 24'hAA5500, 24'hAAAAAA,
		24'h555555, 24'h5555FF, 24'h55FF55, 24'h55FFFF,
		24'hFF5555, 24'hFF55FF, 24'hFFFF55, 24'hFFFFFF
	};

endpackage: text_mode_pkg

/* logic/text_pixel_decoder.sv */
// text pixel colour decoder

`timescale 1ns/100ps

module text_pixel_decoder (
	input  logic                      pixel_clk_i,
	input  logic                      pixel_rstn_i,

	input  logic [7:0]                bits_i,    // glyph row, already registered
	input  logic [2:0]                glyph_x_i, // offset inside glyph, one stage early
	input  text_mode_pkg::text_cell_t cell_i,    // attribute, one stage early
	input  logic                      draw_i,

	output logic [23:0]               rgb_o
);

	logic [23:0] fg_rgb_q, bg_rgb_q; // palette colours, aligned with bits_i
	logic [2:0]  glyph_x_q;
	logic        draw_q;
	logic [2:0]  bit_sel;
	logic        pixel_on;

	// palette lookup runs alongside the font lookup
	always_ff @(posedge pixel_clk_i) begin
		fg_rgb_q  <= text_mode_pkg::cga_palette[cell_i.fg];
		bg_rgb_q  <= text_mode_pkg::cga_palette[cell_i.bg];
		glyph_x_q <= glyph_x_i;
	end

	always_ff @(posedge pixel_clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i)
			draw_q <= 1'b0; // black until the first draw pixel
		else
			draw_q <= draw_i;
	end

	assign bit_sel  = 3'd7 - glyph_x_q; // leftmost pixel is bit 7
	assign pixel_on = bits_i[bit_sel];

	// final select, every input is a register so rgb meets the two cycle budget
	always_comb begin
		if (!draw_q)
			rgb_o = 24'h000000; // blanking
		else if (pixel_on)
			rgb_o = fg_rgb_q;
		else
			rgb_o = bg_rgb_q;
	end

endmodule: text_pixel_decoder

/* logic/vga_timing.sv */
// vga look-ahead timing generator

`timescale 1ns/100ps

`include "text_mode_settings.svh"

module vga_timing (
	input  logic                   pixel_clk_i,
	input  logic                   pixel_rstn_i,

	output text_mode_pkg::scan_pos_t ahead_pos_o, // position TM_LOOKAHEAD pixels ahead
	output logic                   flush_o,     // end of a text row's last scan line
	output logic                   hsync_o,     // aligned with the displayed pixel
	output logic                   vsync_o
);

	logic [9:0] x_q, y_q; // look-ahead counters
	logic       x_last, y_last;
	logic       hsync_n, vsync_n;
	logic [`TM_LOOKAHEAD-1:0] hsync_sr_q, vsync_sr_q;

	assign x_last = (x_q == 10'(`TM_H_TOTAL - 1));
	assign y_last = (y_q == 10'(`TM_V_TOTAL - 1));

	always_ff @(posedge pixel_clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i) begin
			x_q <= 10'(`TM_LOOKAHEAD); // displayed pixel starts at 0,0
			y_q <= '0;
		end else begin
			x_q <= x_last ? '0 : x_q + 1'b1;
			if (x_last)
				y_q <= y_last ? '0 : y_q + 1'b1;
		end
	end

	// sync levels of the look-ahead pixel
	assign hsync_n = ~((x_q >= 10'(`TM_HSYNC_START)) && (x_q < 10'(`TM_HSYNC_END)));
	assign vsync_n = ~((y_q >= 10'(`TM_VSYNC_START)) && (y_q < 10'(`TM_VSYNC_END)));

	assign ahead_pos_o.x       = x_q;
	assign ahead_pos_o.y       = y_q;
	assign ahead_pos_o.in_draw = (x_q < 10'(`TM_H_ACTIVE)) && (y_q < 10'(`TM_V_ACTIVE));
	assign ahead_pos_o.hsync_n = hsync_n;
	assign ahead_pos_o.vsync_n = vsync_n;

	// flush once per text row, never on line 479 so the last row is not cleared early
	assign flush_o = (x_q == 10'(`TM_H_ACTIVE)) &&
		(y_q < 10'(`TM_V_ACTIVE - 1)) &&
		(y_q[3:0] == 4'(`TM_GLYPH_H - 1));

	// delay sync by the look-ahead so it lines up with rgb
	always_ff @(posedge pixel_clk_i or negedge pixel_rstn_i) begin
		if (!pixel_rstn_i) begin
			hsync_sr_q <= '1; // inactive high out of reset
			vsync_sr_q <= '1;
		end else begin
			hsync_sr_q <= {hsync_sr_q[`TM_LOOKAHEAD-2:0], hsync_n};
			vsync_sr_q <= {vsync_sr_q[`TM_LOOKAHEAD-2:0], vsync_n};
		end
	end

	assign hsync_o = hsync_sr_q[`TM_LOOKAHEAD-1];
	assign vsync_o = vsync_sr_q[`TM_LOOKAHEAD-1];

endmodule: vga_timing

/* logic/video_text_mode.sv */
// vga text mode top level

`timescale 1ns/100ps

module video_text_mode (
	input  logic                      pixel_clk_i,
	input  logic                      pixel_rstn_i,

	// host cell writes
	input  logic                      cell_we_i,
	input  text_mode_pkg::text_cell_t cell_i,
	output logic                      full_o,
	output logic                      underrun_o,

	// vga output
	output logic [23:0]               rgb_o,
	output logic                      hsync_o,
	output logic                      vsync_o
);

	text_mode_pkg::text_cell_t fifo_cell, cur_cell;
	text_mode_pkg::scan_pos_t  ahead_pos;

	logic       fifo_pop, fifo_empty;
	logic       flush;
	logic [2:0] glyph_x;
	logic [3:0] glyph_y;
	logic       draw_d1;
	logic [7:0] row_bits;

	cell_fifo cell_fifo_inst (
		.pixel_clk_i  (pixel_clk_i),
		.pixel_rstn_i (pixel_rstn_i),
		.we_i         (cell_we_i),
		.cell_i       (cell_i),
		.pop_i        (fifo_pop),
		.cell_o       (fifo_cell),
		.empty_o      (fifo_empty),
		.full_o       (full_o)
	);

	vga_timing vga_timing_inst (
		.pixel_clk_i  (pixel_clk_i),
		.pixel_rstn_i (pixel_rstn_i),
		.ahead_pos_o  (ahead_pos),
		.flush_o      (flush),
		.hsync_o      (hsync_o),
		.vsync_o      (vsync_o)
	);

	text_line_buffer text_line_buffer_inst (
		.pixel_clk_i  (pixel_clk_i),
		.pixel_rstn_i (pixel_rstn_i),
		.ahead_pos_i  (ahead_pos),
		.flush_i      (flush),
		.fifo_cell_i  (fifo_cell),
		.fifo_empty_i (fifo_empty),
		.fifo_pop_o   (fifo_pop),
		.cell_o       (cur_cell),
		.glyph_x_o    (glyph_x),
		.glyph_y_o    (glyph_y),
		.draw_o       (draw_d1),
		.underrun_o   (underrun_o)
	);

	glyph_rom glyph_rom_inst (
		.pixel_clk_i  (pixel_clk_i),
		.pixel_rstn_i (pixel_rstn_i),
		.code_i       (cur_cell.code),
		.row_i        (glyph_y),
		.bits_o       (row_bits)
	);

	text_pixel_decoder text_pixel_decoder_inst (
		.pixel_clk_i  (pixel_clk_i),
		.pixel_rstn_i (pixel_rstn_i),
		.bits_i       (row_bits),
		.glyph_x_i    (glyph_x),
		.cell_i       (cur_cell),
		.draw_i       (draw_d1),
		.rgb_o        (rgb_o)
	);

endmodule: video_text_mode

/* test/text_mode_tb.sv */
// text mode display testbench

`timescale 1ns/100ps

`include "text_mode_settings.svh"

module text_mode_tb;

	localparam int WAIT_LIMIT = 450000; // a little over one frame of cycles

	// random cell codes including undefined 0x7E which must draw blank
	localparam logic [7:0] CODES [5] = '{8'h00, 8'h20, 8'hDB, 8'h5F, 8'h7E};

	logic                      pixel_clk;
	logic                      pixel_rstn;
	logic                      cell_we;
	text_mode_pkg::text_cell_t cell_in;
	logic                      full;
	logic                      underrun;
	logic [23:0]               rgb;
	logic                      hsync;
	logic                      vsync;

	text_mode_pkg::text_cell_t ref_q [$];        // reference fifo contents
	text_mode_pkg::text_cell_t row_store [`TM_COLS]; // reference line buffer
	logic [31:0]               lcg_state;
	logic                      monitor_on;
	int                        px, py, frame;   // displayed pixel

	video_text_mode video_text_mode_inst (
		.pixel_clk_i  (pixel_clk),
		.pixel_rstn_i (pixel_rstn),
		.cell_we_i    (cell_we),
		.cell_i       (cell_in),
		.full_o       (full),
		.underrun_o   (underrun),
		.rgb_o        (rgb),
		.hsync_o      (hsync),
		.vsync_o      (vsync)
	);

	always #20 pixel_clk = ~pixel_clk; // 25 MHz pixel clock

	task automatic report_mismatch(input string test_name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("FAILED %s: expected %h, actual %h (frame %0d, x %0d, y %0d)",
			test_name, expected, actual, frame, px, py);
		$display("SIMULATION FAILED");
		$fatal(1, "output mismatch");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "wait timed out");
	endtask

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic text_mode_pkg::text_cell_t random_cell();
		text_mode_pkg::text_cell_t c;
		logic [15:0] r;
		r = next_random();
		c.code = CODES[r % 5];
		r = next_random();
		c.fg = r[7:4];
		c.bg = r[11:8];
		return c;
	endfunction

	// expected glyph rows for the codes the stimulus uses
	function automatic logic [7:0] font_row(input logic [7:0] code, input int row);
		if (code == 8'hDB)
			return 8'hFF;
		if (code == 8'h5F && row == 14)
			return 8'hFF;
		return 8'h00;
	endfunction

	function automatic string region_name(input int f, input int y);
		if (f == 0)
			return "frame 0 underrun rows";
		case (y / `TM_GLYPH_H)
			0:       return "row 0 random cells";
			1:       return "row 1 solid cells";
			2:       return "row 2 underscore cells";
			3:       return "row 3 underrun";
			4, 5:    return "fifo overflow rows";
			default: return "blank rows";
		endcase
	endfunction

	// compare one displayed pixel with the reference model
	task automatic check_pixel();
		text_mode_pkg::text_cell_t ref_cell;
		logic [7:0]  bits;
		logic [23:0] exp_rgb;
		logic        exp_hs, exp_vs;
		exp_hs = !(px >= `TM_HSYNC_START && px < `TM_HSYNC_END);
		exp_vs = !(py >= `TM_VSYNC_START && py < `TM_VSYNC_END);
		exp_rgb = 24'h000000;
		if (px < `TM_H_ACTIVE && py < `TM_V_ACTIVE) begin
			// first scan line of a row fetches one cell per column
			if ((py % `TM_GLYPH_H) == 0 && (px % `TM_GLYPH_W) == 0) begin
				if (ref_q.size() != 0)
					row_store[px / `TM_GLYPH_W] = ref_q.pop_front();
				else
					row_store[px / `TM_GLYPH_W] = '0; // empty fifo gives a blank cell
			end
			ref_cell = row_store[px / `TM_GLYPH_W];
			bits = font_row(ref_cell.code, py % `TM_GLYPH_H);
			if (bits[7 - (px % `TM_GLYPH_W)])
				exp_rgb = text_mode_pkg::cga_palette[ref_cell.fg];
			else
				exp_rgb = text_mode_pkg::cga_palette[ref_cell.bg];
		end
		assert (hsync == exp_hs) else report_mismatch("hsync timing", exp_hs, hsync);
		assert (vsync == exp_vs) else report_mismatch("vsync timing", exp_vs, vsync);
		assert (rgb == exp_rgb) else report_mismatch(region_name(frame, py), exp_rgb, rgb);
		// flag is already set by the first fetch after reset and must hold
		if (frame == 1 && py >= 3 * `TM_GLYPH_H)
			assert (underrun == 1'b1) else report_mismatch("sticky underrun", 1, underrun);
	endtask

	// outputs are stable mid cycle
	always @(negedge pixel_clk) begin
		if (monitor_on && frame < 2) begin
			check_pixel();
			px = px + 1;
			if (px == `TM_H_TOTAL) begin
				px = 0;
				py = py + 1;
				if (py == `TM_V_TOTAL) begin
					py = 0;
					frame = frame + 1;
				end
			end
		end
	end

	task automatic wait_for_line(input int f, input int line, input string what);
		int cycles;
		cycles = 0;
		do begin
			@(posedge pixel_clk);
			#2;
			cycles++;
			if (cycles > WAIT_LIMIT)
				report_timeout(what);
		end while (!(frame == f && py == line));
	endtask

	task automatic write_cell(input text_mode_pkg::text_cell_t c);
		assert (full == (ref_q.size() >= `TM_FIFO_DEPTH))
			else report_mismatch("fifo full flag", ref_q.size() >= `TM_FIFO_DEPTH, full);
		cell_in = c;
		cell_we = 1'b1;
		if (ref_q.size() < `TM_FIFO_DEPTH)
			ref_q.push_back(c); // writes into a full fifo are lost
		@(posedge pixel_clk);
		#2;
		cell_we = 1'b0;
	endtask

	initial begin
		text_mode_pkg::text_cell_t c;
		pixel_clk  = 1'b0;
		pixel_rstn = 1'b0;
		cell_we    = 1'b0;
		cell_in    = '0;
		monitor_on = 1'b0;
		lcg_state  = 32'd7064;
		px         = 0;
		py         = 0;
		frame      = 0;

		repeat (5) @(posedge pixel_clk);
		#2;
		pixel_rstn = 1'b1;

		// reset values before the first active edge
		assert (rgb == 24'h000000) else report_mismatch("reset rgb", 0, rgb);
		assert (hsync == 1'b1) else report_mismatch("reset hsync", 1, hsync);
		assert (vsync == 1'b1) else report_mismatch("reset vsync", 1, vsync);
		assert (full == 1'b0) else report_mismatch("reset full", 0, full);
		assert (underrun == 1'b0) else report_mismatch("reset underrun", 0, underrun);
		monitor_on = 1'b1;

		// fill row 0 of frame 1 during the vertical blank of frame 0
		wait_for_line(0, `TM_V_ACTIVE + 1, "frame 0 vertical blank");
		repeat (`TM_COLS) write_cell(random_cell());

		// solid white row 1 once row 0 has been fetched
		wait_for_line(1, 1, "frame 1 line 1");
		c.code = 8'hDB;
		c.fg   = 4'd15;
		c.bg   = 4'd0;
		repeat (`TM_COLS) write_cell(c);

		// white underscores on blue for row 2
		wait_for_line(1, `TM_GLYPH_H + 1, "frame 1 line 17");
		c.code = 8'h5F;
		c.fg   = 4'd15;
		c.bg   = 4'd1;
		repeat (`TM_COLS) write_cell(c);

		// row 3 stays empty and the fifo is overfilled before row 4 starts
		wait_for_line(1, 3 * `TM_GLYPH_H + 1, "frame 1 line 49");
		repeat (`TM_FIFO_DEPTH + 12) write_cell(random_cell());
		assert (full == 1'b1) else report_mismatch("fifo overflow full", 1, full);

		wait_for_line(2, 0, "end of frame 1");
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule: text_mode_tb
